/* Makefile */
VERILATOR ?= verilator
TOP       ?= cdbus_rx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/cdbus_pkg.sv */
// cdbus receive types
// deserializer and frame checker states, crc-16 single bit step
`default_nettype none

`include "cdbus_defines.svh"

package cdbus_pkg;

    typedef enum logic [2:0] {
        WAIT     = 3'b001,
        BUS_IDLE = 3'b010,
        DATA     = 3'b100
    } rx_state_t;

    typedef enum logic [2:0] {HDR_SRC, HDR_DST, HDR_LEN, PAYLOAD, CRC_LO, CRC_HI} frame_state_t;

    // lsb first, one data bit per call
    function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic din);
        logic [15:0] nxt;
        nxt = {1'b0, crc[15:1]};
        if (crc[0] ^ din)
            nxt = nxt ^ `CDBUS_CRC_POLY;
        return nxt;
    endfunction

endpackage

`default_nettype wire

/* design/cdbus_rx_top.sv */
// cdbus_rx_top: receive path top level
// deserializer into byte fifo into frame checker
`timescale 1ns/1ps
`default_nettype none

module cdbus_rx_top (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        rx,
    input  logic [15:0] div_ls,
    input  logic [15:0] div_hs,
    input  logic [7:0]  idle_wait_len,
    input  logic [7:0]  tx_wait_len,
    input  logic        force_wait_idle,
    output logic        bus_idle,
    output logic        tx_permit,
    output logic [7:0]  payload_data,
    output logic        payload_valid,
    output logic        frame_ok,
    output logic        frame_err,
    output logic [7:0]  frame_src,
    output logic [7:0]  frame_dst,
    output logic [7:0]  frame_len,
    output logic        fifo_overflow
);

    rx_byte_if des_if ();   // deserializer to fifo
    rx_byte_if frm_if ();   // fifo to frame checker

    rx_des rx_des_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .div_ls          (div_ls),
        .div_hs          (div_hs),
        .idle_wait_len   (idle_wait_len),
        .tx_wait_len     (tx_wait_len),
        .force_wait_idle (force_wait_idle),
        .rx              (rx),
        .bus_idle        (bus_idle),
        .tx_permit       (tx_permit),
        .byte_out        (des_if.producer)
    );

    rx_byte_fifo rx_byte_fifo_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr       (des_if.consumer),
        .rd       (frm_if.producer),
        .overflow (fifo_overflow)
    );

    rx_frame rx_frame_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .byte_in       (frm_if.consumer),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .frame_ok      (frame_ok),
        .frame_err     (frame_err),
        .frame_src     (frame_src),
        .frame_dst     (frame_dst),
        .frame_len     (frame_len)
    );

endmodule

`default_nettype wire

/* design/rx_byte_fifo.sv */
// rx_byte_fifo: rate buffer for received bytes
// pops every non-empty cycle, sticky overflow on a write into a full buffer
`timescale 1ns/1ps
`default_nettype none

`include "cdbus_defines.svh"

module rx_byte_fifo (
    input  logic        clk,
    input  logic        reset_n,
    rx_byte_if.consumer wr,
    rx_byte_if.producer rd,
    output logic        overflow
);

    localparam int AW = $clog2(`CDBUS_FIFO_DEPTH);

    logic [24:0]   mem [`CDBUS_FIFO_DEPTH];    // {first, crc, data}
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          push;
    logic          pop;

    assign full = (count == (AW + 1)'(`CDBUS_FIFO_DEPTH));
    assign push = wr.strobe && !full;
    assign pop  = (count != '0);

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= {wr.first, wr.crc, wr.data};
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{AW{1'b0}}, push} - {{AW{1'b0}}, pop};
            if (wr.strobe && full)
                overflow <= 1'b1;       // held until reset
        end
    end

    // head entry goes out in the same cycle it is popped
    assign rd.strobe = pop;
    assign {rd.first, rd.crc, rd.data} = mem[rd_ptr];

endmodule

`default_nettype wire

/* design/rx_byte_if.sv */
// received byte stream between deserializer, fifo and frame checker
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if;
    logic [7:0]  data;
    logic        strobe;    // one cycle, no back-pressure
    logic        first;     // opening byte after bus idle
    logic [15:0] crc;       // residue including this byte

    modport producer (output data, output strobe, output first, output crc);
    modport consumer (input data, input strobe, input first, input crc);

endinterface

`default_nettype wire

/* design/rx_des.sv */
// rx_des: serial bus deserializer
// bus state fsm, two-rate bit divider, byte sampler with running crc,
// idle and transmit-permit counters
`timescale 1ns/1ps
`default_nettype none

module rx_des
    import cdbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [15:0] div_ls,           // first byte rate
    input  logic [15:0] div_hs,           // rate for the rest of the frame
    input  logic [7:0]  idle_wait_len,
    input  logic [7:0]  tx_wait_len,
    input  logic        force_wait_idle,
    input  logic        rx,               // already synchronized
    output logic        bus_idle,
    output logic        tx_permit,
    rx_byte_if.producer byte_out
);

    rx_state_t   state;
    logic        allow_data;      // next start bit may follow without idle
    logic        is_first_byte;
    logic        hs_flag;
    logic        byte_end;
    logic [15:0] div_cur;
    logic [15:0] div_cnt;
    logic        bit_inc;
    logic        bit_mid;
    logic        bit_err;
    logic [7:0]  idle_cnt;
    logic [7:0]  tx_wait_cnt;
    logic        tx_permit_r;
    logic        rx_d1;
    logic        rx_d2;
    logic [3:0]  bit_cnt;         // 0 start, 1..8 data, 9 stop
    logic [7:0]  data_r;
    logic        strobe_r;
    logic        crc_clk;
    logic [15:0] crc_val;

    assign bus_idle  = (state == BUS_IDLE);
    assign tx_permit = tx_permit_r & rx;
    assign div_cur   = hs_flag ? div_hs : div_ls;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= WAIT;
            allow_data <= 1'b0;
        end else begin
            case (state)
                WAIT: begin
                    if (!rx && allow_data)
                        state <= DATA;      // next byte of the same frame
                    else if (idle_cnt == idle_wait_len)
                        state <= BUS_IDLE;
                end
                BUS_IDLE: begin
                    if (!rx)
                        state <= DATA;
                end
                DATA: begin
                    if (strobe_r) begin
                        state      <= WAIT;
                        allow_data <= 1'b1;
                    end
                end
                default: state <= WAIT;
            endcase
            if (force_wait_idle || bit_err) begin
                state      <= WAIT;
                allow_data <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            bit_inc <= 1'b0;
            bit_mid <= 1'b0;
        end else begin
            bit_inc <= 1'b0;
            bit_mid <= 1'b0;
            if ((state != DATA && !rx) || bit_err) begin
                div_cnt <= '0;                  // realign on start edge
            end else if (div_cnt >= div_cur) begin
                div_cnt <= '0;
                bit_inc <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 16'd1;
                if (div_cnt + 16'd1 == {1'b0, div_cur[15:1]})
                    bit_mid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_cnt    <= '0;
            tx_wait_cnt <= '0;
            tx_permit_r <= 1'b0;
        end else begin
            if (state != WAIT || !rx)
                idle_cnt <= '0;
            else if (bit_inc)
                idle_cnt <= idle_cnt + 8'd1;

            if (tx_wait_cnt == tx_wait_len)
                tx_permit_r <= 1'b1;
            if (state != BUS_IDLE) begin
                tx_wait_cnt <= '0;
                tx_permit_r <= 1'b0;
            end else if (bit_inc) begin
                tx_wait_cnt <= tx_wait_cnt + 8'd1;
            end
        end
    end

    // mid-bit sampling, strobe lands one cycle after the stop sample
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_d1    <= 1'b1;
            rx_d2    <= 1'b1;
            bit_cnt  <= '0;
            bit_err  <= 1'b0;
            strobe_r <= 1'b0;
            crc_clk  <= 1'b0;
        end else begin
            rx_d1    <= rx;
            rx_d2    <= rx_d1;
            bit_err  <= 1'b0;
            strobe_r <= 1'b0;
            crc_clk  <= 1'b0;
            if (state != DATA) begin
                bit_cnt <= '0;
            end else if (bit_mid) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0) begin
                    bit_err <= rx_d1;           // start bit gone high
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt  <= '0;
                    bit_err  <= !rx_d1;         // stop bit low
                    strobe_r <= rx_d1;
                end else begin
                    crc_clk <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && bit_mid && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            data_r <= {rx_d1, data_r[7:1]};     // lsb first
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            is_first_byte <= 1'b1;
            hs_flag       <= 1'b0;
            byte_end      <= 1'b1;
        end else begin
            if (state == DATA)
                byte_end <= 1'b0;
            if (strobe_r) begin
                is_first_byte <= 1'b0;
                byte_end      <= 1'b1;
            end
            if (state == BUS_IDLE || force_wait_idle || bit_err)
                is_first_byte <= 1'b1;

            // back to low rate once the stop bit has run out
            if (byte_end && bit_inc)
                hs_flag <= 1'b0;
            if (state == WAIT && allow_data && !rx && !is_first_byte)
                hs_flag <= 1'b1;
            if (bit_err || force_wait_idle)
                hs_flag <= 1'b0;
        end
    end

    // crc_clk trails the sample by one cycle, so rx_d2 holds that bit
    serial_crc rx_crc_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (state == BUS_IDLE),
        .data_clk (crc_clk),
        .data_in  (rx_d2),
        .crc_out  (crc_val)
    );

    assign byte_out.data   = data_r;
    assign byte_out.strobe = strobe_r;
    assign byte_out.first  = is_first_byte;
    assign byte_out.crc    = crc_val;

endmodule

`default_nettype wire

/* design/rx_frame.sv */
// rx_frame: frame field splitter and crc check
// latches header fields, passes payload, pulses ok or err per frame
`timescale 1ns/1ps
`default_nettype none

`include "cdbus_defines.svh"

module rx_frame
    import cdbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    rx_byte_if.consumer byte_in,
    output logic [7:0]  payload_data,
    output logic        payload_valid,
    output logic        frame_ok,
    output logic        frame_err,
    output logic [7:0]  frame_src,
    output logic [7:0]  frame_dst,
    output logic [7:0]  frame_len
);

    frame_state_t field;
    logic [7:0]   remain;         // payload bytes still to come

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            field         <= HDR_SRC;
            remain        <= '0;
            payload_valid <= 1'b0;
            frame_ok      <= 1'b0;
            frame_err     <= 1'b0;
        end else begin
            payload_valid <= 1'b0;
            frame_ok      <= 1'b0;
            frame_err     <= 1'b0;
            if (byte_in.strobe) begin
                if (byte_in.first && field != HDR_SRC) begin
                    // new frame cut into the old one, this byte is its source
                    frame_err <= 1'b1;
                    field     <= HDR_DST;
                end else begin
                    case (field)
                        HDR_SRC: field <= HDR_DST;
                        HDR_DST: field <= HDR_LEN;
                        HDR_LEN: begin
                            remain <= byte_in.data;
                            if (byte_in.data > 8'(`CDBUS_MAX_LEN)) begin
                                frame_err <= 1'b1;
                                field     <= HDR_SRC;
                            end else if (byte_in.data == 8'd0) begin
                                field <= CRC_LO;
                            end else begin
                                field <= PAYLOAD;
                            end
                        end
                        PAYLOAD: begin
                            payload_valid <= 1'b1;
                            remain        <= remain - 8'd1;
                            if (remain == 8'd1)
                                field <= CRC_LO;
                        end
                        CRC_LO: field <= CRC_HI;
                        CRC_HI: begin
                            frame_ok  <= (byte_in.crc == 16'h0000);   // zero residue
                            frame_err <= (byte_in.crc != 16'h0000);
                            field     <= HDR_SRC;
                        end
                        default: field <= HDR_SRC;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_in.strobe) begin
            payload_data <= byte_in.data;
            if (field == HDR_SRC || byte_in.first)
                frame_src <= byte_in.data;
            else if (field == HDR_DST)
                frame_dst <= byte_in.data;
            else if (field == HDR_LEN)
                frame_len <= byte_in.data;
        end
    end

endmodule

`default_nettype wire

/* design/serial_crc.sv */
// serial_crc: bit-serial crc-16 register
// cleared to the init value, advanced one bit per data_clk
`timescale 1ns/1ps
`default_nettype none

`include "cdbus_defines.svh"

module serial_crc
    import cdbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clean,      // hold at init
    input  logic        data_clk,
    input  logic        data_in,
    output logic [15:0] crc_out
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            crc_out <= `CDBUS_CRC_INIT;
        else if (clean)
            crc_out <= `CDBUS_CRC_INIT;
        else if (data_clk)
            crc_out <= crc16_bit(crc_out, data_in);
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/cdbus_pkg.sv
design/rx_byte_if.sv
design/serial_crc.sv
design/rx_des.sv
design/rx_byte_fifo.sv
design/rx_frame.sv
design/cdbus_rx_top.sv
tb/cdbus_rx_assertions.sv
tb/cdbus_rx_tb.sv

/* include/cdbus_defines.svh */
// cdbus receive path constants
// crc start value and polynomial, fifo depth, payload limit
`ifndef CDBUS_DEFINES_SVH
`define CDBUS_DEFINES_SVH

// crc-16 in the reflected modbus form, no final xor
`define CDBUS_CRC_INIT    16'hffff
`define CDBUS_CRC_POLY    16'ha001

`define CDBUS_FIFO_DEPTH  16        // power of two, pointers wrap
`define CDBUS_MAX_LEN     253       // largest payload length byte

`endif

/* tb/cdbus_rx_assertions.sv */
// concurrent checks on the deserializer and the frame checker
// one-hot state, exclusive result pulses, single-cycle byte strobe
`timescale 1ns/1ps
`default_nettype none

module cdbus_rx_assertions (
    input wire       clk,
    input wire       reset_n,
    input wire [2:0] state,
    input wire       strobe,
    input wire       frame_ok,
    input wire       frame_err
);

    a_state_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(state))
        else $error("deserializer state is not one-hot");

    a_result_excl: assert property (@(posedge clk) disable iff (!reset_n) !(frame_ok && frame_err))
        else $error("frame_ok and frame_err high together");

    a_strobe_single: assert property (@(posedge clk) disable iff (!reset_n) strobe |=> !strobe)
        else $error("byte strobe high two cycles in a row");

endmodule

bind rx_des cdbus_rx_assertions des_checks_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .state     (state),
    .strobe    (strobe_r),
    .frame_ok  (1'b0),
    .frame_err (1'b0)
);

bind rx_frame cdbus_rx_assertions frame_checks_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .state     (3'b001),       // no state here
    .strobe    (1'b0),
    .frame_ok  (frame_ok),
    .frame_err (frame_err)
);

`default_nettype wire

/* tb/cdbus_rx_tb.sv */
// cdbus receive path testbench
// clock, reset, serial line driver, lcg stimulus, reference crc,
// payload and frame result monitor, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "cdbus_defines.svh"

module cdbus_rx_tb import cdbus_pkg::*; ();

    localparam int DIV_LS = 39;
    localparam int DIV_HS = 9;
    localparam int IDLE_LEN = 10;
    localparam int TX_LEN = 20;
    localparam int N_RANDOM = 8;
    localparam int MAX_TEST_LEN = 20;
    localparam int N_FRAMES = N_RANDOM + 5;
    // every frame at the low rate plus its idle gap, plus the startup wait
    localparam longint WATCHDOG_NS = longint'(N_FRAMES) * ((MAX_TEST_LEN + 5) * 10 + IDLE_LEN + 2)
                                     * (DIV_LS + 1) * 10 + (IDLE_LEN + TX_LEN + 2) * (DIV_LS + 1) * 10;

    logic        clk;
    logic        reset_n;
    logic        rx;
    logic [15:0] div_ls;
    logic [15:0] div_hs;
    logic [7:0]  idle_wait_len;
    logic [7:0]  tx_wait_len;
    logic        force_wait_idle;
    logic        bus_idle;
    logic        tx_permit;
    logic [7:0]  payload_data;
    logic        payload_valid;
    logic        frame_ok;
    logic        frame_err;
    logic [7:0]  frame_src;
    logic [7:0]  frame_dst;
    logic [7:0]  frame_len;
    logic        fifo_overflow;

    logic [7:0]  tx_bytes [0:31];    // frame as sent on the line
    int          tx_n;
    logic [7:0]  exp_q [$];          // payload still to arrive
    logic [7:0]  exp_src;
    logic [7:0]  exp_dst;
    logic [7:0]  exp_len;
    int          ok_cnt = 0;
    int          err_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd10;

    cdbus_rx_top cdbus_rx_top_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // crc over header and payload, lsb of each byte first
    function automatic logic [15:0] frame_crc(input int n);
        logic [15:0] crc;
        crc = `CDBUS_CRC_INIT;
        for (int i = 0; i < n; i++)
            for (int b = 0; b < 8; b++)
                crc = crc16_bit(crc, tx_bytes[i][b]);
        return crc;
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_range(input string name, input int act, input int lo, input int hi);
        checks++;
        if (act < lo || act > hi) begin
            errors++;
            $display("%s took %0d cycles, outside %0d to %0d", name, act, lo, hi);
        end
    endtask

    task automatic build_frame(input int len, input logic [7:0] src, input logic [7:0] dst);
        logic [15:0] crc;
        tx_bytes[0] = src;
        tx_bytes[1] = dst;
        tx_bytes[2] = 8'(len);
        for (int i = 0; i < len; i++)
            tx_bytes[3 + i] = lcg_byte();
        crc = frame_crc(3 + len);
        tx_bytes[3 + len] = crc[7:0];    // low byte first, residue ends at zero
        tx_bytes[4 + len] = crc[15:8];
        tx_n = 5 + len;
        exp_src = src;
        exp_dst = dst;
        exp_len = 8'(len);
    endtask

    task automatic expect_payload(input int count);
        for (int i = 0; i < count; i++)
            exp_q.push_back(tx_bytes[3 + i]);
    endtask

    task automatic send_char(input logic [7:0] b, input int div, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx <= bits[i];
            repeat (div + 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input int n_send, input int bad_idx);
        for (int i = 0; i < n_send; i++)
            send_char(tx_bytes[i], (i == 0) ? DIV_LS : DIV_HS, 1'(i == bad_idx));
        rx <= 1'b1;
        @(posedge clk);
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (bus_idle !== 1'b1 && n < 4 * IDLE_LEN * (DIV_LS + 1)) begin
            @(posedge clk);
            n++;
        end
        if (bus_idle !== 1'b1) begin
            errors++;
            $display("bus did not return to idle");
        end
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        while (ok_cnt + err_cnt < target && n < 50 * (DIV_LS + 1)) begin
            @(posedge clk);
            n++;
        end
        if (ok_cnt + err_cnt < target) begin
            errors++;
            $display("frame result pulse never came");
        end
    endtask

    task automatic good_frame(input int len, input int aborts);
        int ok0;
        int err0;
        logic [7:0] src;
        logic [7:0] dst;
        wait_bus_idle();
        ok0 = ok_cnt;
        err0 = err_cnt;
        src = lcg_byte();
        dst = lcg_byte();
        build_frame(len, src, dst);
        expect_payload(len);
        send_frame(tx_n, -1);
        wait_results(ok0 + err0 + 1 + aborts);
        check_value("frame_ok count", ok0 + 1, ok_cnt);
        check_value("frame_err count", err0 + aborts, err_cnt);
        check_value("payload left over", 0, exp_q.size());
    endtask

    // payload order and result pulse counts
    always @(negedge clk) begin
        logic [7:0] exp_b;
        if (reset_n) begin
            if (payload_valid) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("payload byte %02h arrived with none expected", payload_data);
                end else begin
                    exp_b = exp_q.pop_front();
                    if (payload_data !== exp_b) begin
                        errors++;
                        $display("FAILED payload: expected %02h, actual %02h", exp_b, payload_data);
                    end
                end
            end
            if (frame_ok) begin
                ok_cnt++;
                check_value("frame_src", int'(exp_src), int'(frame_src));
                check_value("frame_dst", int'(exp_dst), int'(frame_dst));
                check_value("frame_len", int'(exp_len), int'(frame_len));
            end
            if (frame_err)
                err_cnt++;
        end
    end

    initial begin
        int cyc;
        int ok0;
        int err0;
        rx = 1'b1;
        reset_n = 1'b0;
        div_ls = 16'(DIV_LS);
        div_hs = 16'(DIV_HS);
        idle_wait_len = 8'(IDLE_LEN);
        tx_wait_len = 8'(TX_LEN);
        force_wait_idle = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        // idle line, bus_idle then tx_permit
        cyc = 0;
        while (!bus_idle && cyc < 2 * IDLE_LEN * (DIV_LS + 1)) begin
            @(posedge clk);
            cyc++;
        end
        check_range("bus_idle", cyc, IDLE_LEN * (DIV_LS + 1), (IDLE_LEN + 1) * (DIV_LS + 1) + 4);
        check_value("tx_permit at bus idle", 0, int'(tx_permit));
        cyc = 0;
        while (!tx_permit && cyc < 2 * TX_LEN * (DIV_LS + 1)) begin
            @(posedge clk);
            cyc++;
        end
        check_range("tx_permit", cyc, (TX_LEN - 1) * (DIV_LS + 1), (TX_LEN + 1) * (DIV_LS + 1) + 4);
        check_value("pulses before traffic", 0, ok_cnt + err_cnt);

        for (int f = 0; f < N_RANDOM; f++)
            good_frame(int'(lcg_byte()) % (MAX_TEST_LEN + 1), 0);

        // payload bit flipped after the crc
        wait_bus_idle();
        ok0 = ok_cnt;
        err0 = err_cnt;
        build_frame(6, 8'h21, 8'h42);
        tx_bytes[5] = tx_bytes[5] ^ 8'h10;
        expect_payload(6);
        send_frame(tx_n, -1);
        wait_results(ok0 + err0 + 1);
        check_value("corrupt frame_ok count", ok0, ok_cnt);
        check_value("corrupt frame_err count", err0 + 1, err_cnt);
        check_value("corrupt payload left over", 0, exp_q.size());

        // stop bit low in the second payload byte
        wait_bus_idle();
        err0 = err_cnt;
        build_frame(3, 8'h31, 8'h52);
        expect_payload(1);
        send_frame(tx_n, 4);
        wait_bus_idle();
        check_value("frame_err before abort", err0, err_cnt);
        good_frame(int'(lcg_byte()) % (MAX_TEST_LEN + 1), 1);

        // force_wait_idle with transmit permitted
        wait_bus_idle();
        cyc = 0;
        while (!tx_permit && cyc < 2 * TX_LEN * (DIV_LS + 1)) begin
            @(posedge clk);
            cyc++;
        end
        check_value("tx_permit before force", 1, int'(tx_permit));
        force_wait_idle <= 1'b1;
        @(posedge clk);
        force_wait_idle <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("bus_idle after force", 0, int'(bus_idle));
        check_value("tx_permit after force", 0, int'(tx_permit));

        // force_wait_idle between payload bytes, a byte right after it is ignored
        wait_bus_idle();
        build_frame(5, 8'h41, 8'h62);
        expect_payload(2);
        send_frame(5, -1);
        force_wait_idle <= 1'b1;
        @(posedge clk);
        force_wait_idle <= 1'b0;
        send_char(tx_bytes[5], DIV_HS, 1'b0);
        good_frame(7, 1);
        check_value("fifo_overflow", 0, int'(fifo_overflow));

        $display("checks: %0d, errors: %0d, frame_ok: %0d, frame_err: %0d",
                 checks, errors, ok_cnt, err_cnt);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
